// File: design/rv_pkg.sv
package rv_pkg;

  // ==============================
  // widths and address map
  // ==============================

  localparam int unsigned xlen = 32;
  localparam int unsigned reg_count = 32;

  localparam logic [11:0] addr_instr = 12'h000;
  localparam logic [11:0] addr_retired = 12'h080;
  localparam logic [11:0] addr_illegal = 12'h084;
  localparam logic [11:0] addr_reg_base = 12'h100; // x0, then x1..x31 at a stride of 4.

  localparam logic [1:0] resp_okay = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_pass // result is the immediate itself.
  } alu_op_e;

  // ==============================
  // instruction word views
  // ==============================

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_full_t;

  // funct4[3:1] is funct3 of the CI formats, funct4[0] is their imm[5].
  typedef struct packed {
    logic [15:0] upper;
    logic [3:0] funct4;
    logic [4:0] rd_rs1;
    logic [4:0] rs2_imm;
    logic [1:0] quadrant;
  } instr_comp_t;

  typedef union packed {
    instr_full_t full;
    instr_comp_t comp;
  } instr_word_u;

  // ==============================
  // stage and bus structs
  // ==============================

  typedef struct packed {
    logic valid;
    logic illegal;
    logic wren;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic use_imm;
    logic [xlen-1:0] imm;
    alu_op_e alu_op;
  } decoded_t;

  typedef struct packed {
    logic valid;
    logic illegal;
    logic wren;
    logic [4:0] rd;
    logic [xlen-1:0] value;
  } exec_t;

  typedef struct packed {
    logic [11:0] awaddr;
    logic awvalid;
    logic [xlen-1:0] wdata;
    logic [3:0] wstrb;
    logic wvalid;
    logic bready;
    logic [11:0] araddr;
    logic arvalid;
    logic rready;
  } axil_req_t;

  typedef struct packed {
    logic awready;
    logic wready;
    logic bvalid;
    logic [1:0] bresp;
    logic arready;
    logic rvalid;
    logic [xlen-1:0] rdata;
    logic [1:0] rresp;
  } axil_rsp_t;

endpackage

// File: design/axil_port.sv
`timescale 1ns/10ps

module axil_port (
  input logic clock,
  input logic reset,
  input rv_pkg::axil_req_t axil_req,
  output rv_pkg::axil_rsp_t axil_rsp,
  output logic instr_valid,
  output rv_pkg::instr_word_u instr,
  output logic [4:0] rd_index,
  input logic [31:0] rd_value,
  input logic [31:0] retired,
  input logic [31:0] illegal_count
);
  import rv_pkg::*;

  logic pending;
  instr_word_u pending_word;
  logic bvalid_q;
  logic [1:0] bresp_q;
  logic rvalid_q;
  logic [xlen-1:0] rdata_q;
  logic [1:0] rresp_q;

  logic wr_ready;
  logic wr_fire;
  logic wr_ok;
  logic rd_fire;
  logic [xlen-1:0] rd_data;
  logic [1:0] rd_resp;

  // AW and W are taken together, one word at a time.
  assign wr_ready = ~pending & ~bvalid_q;
  assign wr_fire = axil_req.awvalid & axil_req.wvalid & wr_ready;
  assign wr_ok = (axil_req.awaddr == addr_instr) && (axil_req.wstrb == 4'hf);
  assign rd_fire = axil_req.arvalid & ~rvalid_q;

  assign instr_valid = pending; // the word is presented for exactly one cycle.
  assign instr = pending_word;
  assign rd_index = axil_req.araddr[6:2];

  always_comb begin
    rd_data = '0;
    rd_resp = resp_slverr;
    if (axil_req.araddr == addr_retired) begin
      rd_data = retired;
      rd_resp = resp_okay;
    end else if (axil_req.araddr == addr_illegal) begin
      rd_data = illegal_count;
      rd_resp = resp_okay;
    end else if ((axil_req.araddr[11:7] == addr_reg_base[11:7]) &&
                 (axil_req.araddr[1:0] == 2'b00)) begin
      rd_data = rd_value;
      rd_resp = resp_okay;
    end
  end

  always_comb begin
    axil_rsp.awready = wr_ready;
    axil_rsp.wready = wr_ready;
    axil_rsp.bvalid = bvalid_q;
    axil_rsp.bresp = bresp_q;
    axil_rsp.arready = ~rvalid_q;
    axil_rsp.rvalid = rvalid_q;
    axil_rsp.rdata = rdata_q;
    axil_rsp.rresp = rresp_q;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      pending <= 1'b0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      pending <= wr_fire & wr_ok; // a rejected word is simply dropped.
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wr_fire) begin
      pending_word <= axil_req.wdata;
      bresp_q <= wr_ok ? resp_okay : resp_slverr;
    end
    if (rd_fire) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  bvalid_hold: assert property (@(posedge clock) disable iff (!reset)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid);

endmodule

// File: design/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
  input logic clock,
  input logic reset,
  input logic instr_valid,
  input rv_pkg::instr_word_u instr,
  output rv_pkg::decoded_t dec
);
  import rv_pkg::*;

  decoded_t r, rin;
  decoded_t v;
  logic legal;

  always_comb begin
    v = '0;
    legal = 1'b0;

    v.valid = instr_valid;
    v.rd = instr.full.rd;
    v.rs1 = instr.full.rs1;
    v.rs2 = instr.full.rs2;
    v.imm = {{20{instr.full.funct7[6]}}, instr.full.funct7, instr.full.rs2}; // I-type.
    v.alu_op = alu_add;

    if (instr.comp.quadrant == 2'b11) begin
      // ==============================
      // 32-bit formats
      // ==============================
      case (instr.full.opcode)
        7'b0110011: begin
          v.wren = 1'b1;
          if (instr.full.funct7 == 7'b0000000) begin
            legal = 1'b1;
            case (instr.full.funct3)
              3'b000: v.alu_op = alu_add;
              3'b001: v.alu_op = alu_sll;
              3'b010: v.alu_op = alu_slt;
              3'b011: v.alu_op = alu_sltu;
              3'b100: v.alu_op = alu_xor;
              3'b101: v.alu_op = alu_srl;
              3'b110: v.alu_op = alu_or;
              default: v.alu_op = alu_and;
            endcase
          end else if (instr.full.funct7 == 7'b0100000) begin
            if (instr.full.funct3 == 3'b000) begin
              legal = 1'b1;
              v.alu_op = alu_sub;
            end else if (instr.full.funct3 == 3'b101) begin
              legal = 1'b1;
              v.alu_op = alu_sra;
            end
          end
        end
        7'b0010011: begin
          v.wren = 1'b1;
          v.use_imm = 1'b1;
          legal = 1'b1;
          case (instr.full.funct3)
            3'b000: v.alu_op = alu_add;
            3'b010: v.alu_op = alu_slt;
            3'b011: v.alu_op = alu_sltu;
            3'b100: v.alu_op = alu_xor;
            3'b110: v.alu_op = alu_or;
            3'b111: v.alu_op = alu_and;
            3'b001: begin
              v.alu_op = alu_sll;
              legal = (instr.full.funct7 == 7'b0000000);
            end
            default: begin
              v.alu_op = (instr.full.funct7[5]) ? alu_sra : alu_srl;
              legal = (instr.full.funct7 == 7'b0000000) || (instr.full.funct7 == 7'b0100000);
            end
          endcase
        end
        7'b0110111: begin
          legal = 1'b1;
          v.wren = 1'b1;
          v.use_imm = 1'b1;
          v.imm = {instr.full.funct7, instr.full.rs2, instr.full.rs1, instr.full.funct3, 12'b0};
          v.alu_op = alu_pass;
        end
        default: legal = 1'b0;
      endcase
    end else begin
      // ==============================
      // compressed formats
      // ==============================
      v.rd = instr.comp.rd_rs1;
      v.rs1 = instr.comp.rd_rs1;
      v.rs2 = instr.comp.rs2_imm;
      v.imm = {{27{instr.comp.funct4[0]}}, instr.comp.rs2_imm};
      v.wren = 1'b1;
      if (instr.comp.quadrant == 2'b01) begin
        if (instr.comp.funct4[3:1] == 3'b010) begin
          legal = 1'b1; // c.li
          v.use_imm = 1'b1;
          v.alu_op = alu_pass;
        end else if (instr.comp.funct4[3:1] == 3'b000) begin
          legal = 1'b1; // c.addi
          v.use_imm = 1'b1;
        end
      end else if (instr.comp.quadrant == 2'b10 && instr.comp.rs2_imm != 5'd0) begin
        if (instr.comp.funct4 == 4'b1000) begin
          legal = 1'b1; // c.mv adds rs2 to x0.
          v.rs1 = 5'd0;
        end else if (instr.comp.funct4 == 4'b1001) begin
          legal = 1'b1; // c.add
        end
      end
    end

    if (!legal) begin
      v.illegal = 1'b1;
      v.wren = 1'b0;
    end

    if (v.rd == 5'd0) begin
      v.wren = 1'b0;
    end

    if (!instr_valid) begin
      v.illegal = 1'b0;
      v.wren = 1'b0;
    end

    rin = v;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      r <= '0;
    end else begin
      r <= rin;
    end
  end

  assign dec = r;

  no_illegal_write: assert property (@(posedge clock) disable iff (!reset)
    !(dec.illegal && dec.wren));

endmodule

// File: design/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
  input logic clock,
  input logic reset,
  input rv_pkg::decoded_t dec,
  output logic [4:0] rs1_index,
  output logic [4:0] rs2_index,
  input logic [31:0] rs1_value,
  input logic [31:0] rs2_value,
  output rv_pkg::exec_t ex
);
  import rv_pkg::*;

  logic [xlen-1:0] src_a;
  logic [xlen-1:0] src_b;
  logic [xlen-1:0] op_b;
  logic [4:0] shamt;
  logic [xlen-1:0] result;
  logic fwd_a;
  logic fwd_b;

  assign rs1_index = dec.rs1;
  assign rs2_index = dec.rs2;

  // ==============================
  // operand fetch and bypass
  // ==============================

  // the previous result is not yet in the register file.
  assign fwd_a = ex.valid && ex.wren && (ex.rd == dec.rs1);
  assign fwd_b = ex.valid && ex.wren && (ex.rd == dec.rs2);
  assign src_a = fwd_a ? ex.value : rs1_value;
  assign src_b = fwd_b ? ex.value : rs2_value;

  assign op_b = dec.use_imm ? dec.imm : src_b;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      alu_add: result = src_a + op_b;
      alu_sub: result = src_a - op_b;
      alu_and: result = src_a & op_b;
      alu_or: result = src_a | op_b;
      alu_xor: result = src_a ^ op_b;
      alu_sll: result = src_a << shamt;
      alu_srl: result = src_a >> shamt;
      alu_sra: result = $unsigned($signed(src_a) >>> shamt);
      alu_slt: result = {{(xlen-1){1'b0}}, $signed(src_a) < $signed(op_b)};
      alu_sltu: result = {{(xlen-1){1'b0}}, src_a < op_b};
      alu_pass: result = dec.imm;
      default: result = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ex <= '0;
    end else begin
      ex.valid <= dec.valid;
      ex.illegal <= dec.illegal;
      ex.wren <= dec.wren;
      ex.rd <= dec.rd;
      ex.value <= result;
    end
  end

endmodule

// File: design/result_stage.sv
`timescale 1ns/10ps

module result_stage (
  input logic clock,
  input logic reset,
  input rv_pkg::exec_t ex,
  input logic [4:0] rs1_index,
  input logic [4:0] rs2_index,
  input logic [4:0] rd_index,
  output logic [31:0] rs1_value,
  output logic [31:0] rs2_value,
  output logic [31:0] rd_value,
  output logic [31:0] retired,
  output logic [31:0] illegal_count
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [reg_count];
  logic write_en;

  assign write_en = ex.valid && ex.wren && (ex.rd != 5'd0);

  // x0 reads as zero whatever the array holds.
  assign rs1_value = (rs1_index == 5'd0) ? '0 : regs[rs1_index];
  assign rs2_value = (rs2_index == 5'd0) ? '0 : regs[rs2_index];
  assign rd_value = (rd_index == 5'd0) ? '0 : regs[rd_index];

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[ex.rd] <= ex.value;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      retired <= '0;
      illegal_count <= '0;
    end else if (ex.valid) begin
      retired <= retired + 32'd1; // illegal words retire as well.
      if (ex.illegal) begin
        illegal_count <= illegal_count + 32'd1;
      end
    end
  end

  x0_never_written: assert property (@(posedge clock) disable iff (!reset)
    ex.valid && ex.wren |-> ex.rd != 5'd0);

endmodule

// File: design/rv_issue_top.sv
`timescale 1ns/10ps

module rv_issue_top (
  input logic clock,
  input logic reset,
  input rv_pkg::axil_req_t axil_req,
  output rv_pkg::axil_rsp_t axil_rsp
);
  import rv_pkg::*;

  logic instr_valid;
  instr_word_u instr;
  decoded_t dec;
  exec_t ex;

  logic [4:0] rs1_index;
  logic [4:0] rs2_index;
  logic [4:0] rd_index;
  logic [xlen-1:0] rs1_value;
  logic [xlen-1:0] rs2_value;
  logic [xlen-1:0] rd_value;
  logic [xlen-1:0] retired;
  logic [xlen-1:0] illegal_count;

  axil_port u_axil_port (
    .clock(clock),
    .reset(reset),
    .axil_req(axil_req),
    .axil_rsp(axil_rsp),
    .instr_valid(instr_valid),
    .instr(instr),
    .rd_index(rd_index),
    .rd_value(rd_value),
    .retired(retired),
    .illegal_count(illegal_count)
  );

  decode_stage u_decode_stage (
    .clock(clock),
    .reset(reset),
    .instr_valid(instr_valid),
    .instr(instr),
    .dec(dec)
  );

  execute_stage u_execute_stage (
    .clock(clock),
    .reset(reset),
    .dec(dec),
    .rs1_index(rs1_index),
    .rs2_index(rs2_index),
    .rs1_value(rs1_value),
    .rs2_value(rs2_value),
    .ex(ex)
  );

  result_stage u_result_stage (
    .clock(clock),
    .reset(reset),
    .ex(ex),
    .rs1_index(rs1_index),
    .rs2_index(rs2_index),
    .rd_index(rd_index),
    .rs1_value(rs1_value),
    .rs2_value(rs2_value),
    .rd_value(rd_value),
    .retired(retired),
    .illegal_count(illegal_count)
  );

endmodule

// File: sim/tb_tasks.svh
`ifndef tb_tasks_svh
`define tb_tasks_svh

// ==============================
// checks and random numbers
// ==============================

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
  if (got !== expected) begin
    $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, expected);
    $display("TESTS FAILED");
    $fatal(1, "mismatch on %s", name);
  end
endtask

task automatic report_timeout(input string what);
  $display("the DUT gave no response while waiting for %s", what);
  $display("TESTS FAILED");
  $fatal(1, "timeout");
endtask

function automatic logic [31:0] xorshift32();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

// ==============================
// AXI4-Lite master
// ==============================

// both bus tasks start and end 1 ns after a rising edge.
task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, output logic [1:0] resp);
  int cycles;
  axil_req.awaddr = addr;
  axil_req.wdata = data;
  axil_req.wstrb = strb;
  axil_req.awvalid = 1'b1;
  axil_req.wvalid = 1'b1;
  axil_req.bready = 1'b1;
  cycles = 0;
  do begin
    @(posedge clock);
    cycles++;
    if (cycles > timeout_cycles) report_timeout("the write address and data handshake");
  end while (!(axil_rsp.awready && axil_rsp.wready));
  #1;
  axil_req.awvalid = 1'b0;
  axil_req.wvalid = 1'b0;
  cycles = 0;
  do begin
    @(posedge clock);
    cycles++;
    if (cycles > timeout_cycles) report_timeout("the write response");
  end while (!axil_rsp.bvalid);
  resp = axil_rsp.bresp;
  #1;
  axil_req.bready = 1'b0;
endtask

task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
  int cycles;
  axil_req.araddr = addr;
  axil_req.arvalid = 1'b1;
  axil_req.rready = 1'b1;
  cycles = 0;
  do begin
    @(posedge clock);
    cycles++;
    if (cycles > timeout_cycles) report_timeout("the read address handshake");
  end while (!axil_rsp.arready);
  #1;
  axil_req.arvalid = 1'b0;
  cycles = 0;
  do begin
    @(posedge clock);
    cycles++;
    if (cycles > timeout_cycles) report_timeout("the read data");
  end while (!axil_rsp.rvalid);
  data = axil_rsp.rdata;
  resp = axil_rsp.rresp;
  #1;
  axil_req.rready = 1'b0;
endtask

// ==============================
// instruction encoders
// ==============================

function automatic logic [31:0] r_type_word(input logic [6:0] funct7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] funct3,
                                            input logic [4:0] rd);
  return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] funct3, input logic [4:0] rd);
  return {imm, rs1, funct3, rd, 7'b0010011};
endfunction

function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
  return {imm, rd, 7'b0110111};
endfunction

// compressed words carry random bits in the upper half.
function automatic logic [31:0] ci_word(input logic [2:0] funct3, input logic [4:0] rd,
                                        input logic [5:0] imm);
  logic [31:0] noise;
  noise = xorshift32();
  return {noise[31:16], funct3, imm[5], rd, imm[4:0], 2'b01};
endfunction

function automatic logic [31:0] cr_word(input logic [3:0] funct4, input logic [4:0] rd,
                                        input logic [4:0] rs2);
  logic [31:0] noise;
  noise = xorshift32();
  return {noise[31:16], funct4, rd, rs2, 2'b10};
endfunction

`endif

// File: sim/tb_rv_issue.sv
`timescale 1ns/10ps

module tb_rv_issue;
  import rv_pkg::*;

  localparam int timeout_cycles = 100;

  logic clock;
  logic reset;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;

  logic [31:0] rng_state;
  logic [31:0] model_regs [32]; // expected register file, x0 stays zero.
  int unsigned retired_exp;
  int unsigned illegal_exp;

  rv_issue_top u_rv_issue_top (
    .clock(clock),
    .reset(reset),
    .axil_req(axil_req),
    .axil_rsp(axil_rsp)
  );

  always #10 clock = ~clock;

  `include "tb_tasks.svh"

  // ==============================
  // reference model
  // ==============================

  function automatic logic [31:0] alu_model(input logic [2:0] funct3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (funct3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic issue(input logic [31:0] word);
    logic [1:0] resp;
    axil_write(addr_instr, word, 4'hf, resp);
    check_value("bresp", {30'd0, resp}, {30'd0, resp_okay});
    retired_exp++;
  endtask

  task automatic run_r(input logic [2:0] funct3, input logic alt, input logic [4:0] rd,
                       input logic [4:0] rs1, input logic [4:0] rs2);
    issue(r_type_word(alt ? 7'b0100000 : 7'b0000000, rs2, rs1, funct3, rd));
    if (rd != 5'd0) model_regs[rd] = alu_model(funct3, alt, model_regs[rs1], model_regs[rs2]);
  endtask

  task automatic run_i(input logic [2:0] funct3, input logic alt, input logic [4:0] rd,
                       input logic [4:0] rs1, input logic [11:0] imm);
    logic [11:0] field;
    logic [31:0] b;
    field = imm;
    b = {{20{imm[11]}}, imm};
    if (funct3 == 3'd1 || funct3 == 3'd5) begin
      field = {alt ? 7'b0100000 : 7'b0000000, imm[4:0]}; // shifts take a 5-bit amount.
      b = {27'd0, imm[4:0]};
    end
    issue(i_type_word(field, rs1, funct3, rd));
    if (rd != 5'd0) model_regs[rd] = alu_model(funct3, alt, model_regs[rs1], b);
  endtask

  task automatic load_value(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800; // ADDI sign-extends, so round the upper part.
    issue(lui_word(upper[31:12], rd));
    issue(i_type_word(value[11:0], rd, 3'd0, rd));
    model_regs[rd] = value;
  endtask

  task automatic read_expect(input logic [11:0] addr, input string name,
                             input logic [31:0] expected, input logic [1:0] expected_resp);
    logic [31:0] data;
    logic [1:0] resp;
    axil_read(addr, data, resp);
    check_value(name, data, expected);
    check_value("rresp", {30'd0, resp}, {30'd0, expected_resp});
  endtask

  task automatic wait_retired();
    logic [31:0] data;
    logic [1:0] resp;
    int polls;
    polls = 0;
    do begin
      axil_read(addr_retired, data, resp);
      polls++;
      if (polls > timeout_cycles) report_timeout("the retired counter to reach its count");
    end while (data < retired_exp);
    check_value("retired", data, retired_exp);
    read_expect(addr_illegal, "illegal_count", illegal_exp, resp_okay);
  endtask

  task automatic check_regs();
    for (int i = 0; i < 32; i++) begin
      read_expect(addr_reg_base + 12'(4 * i), $sformatf("x%0d", i), model_regs[i], resp_okay);
    end
  endtask

  // ==============================
  // directed tests
  // ==============================

  task automatic reset_state_reads_zero();
    read_expect(addr_retired, "retired", 32'd0, resp_okay);
    read_expect(addr_illegal, "illegal_count", 32'd0, resp_okay);
    check_regs();
  endtask

  task automatic alu_ops_match_model();
    logic [4:0] rd;
    logic [31:0] noise;
    load_value(5'd1, xorshift32());
    load_value(5'd2, xorshift32());
    rd = 5'd3;
    for (int f = 0; f < 8; f++) begin
      run_r(3'(f), 1'b0, rd, 5'd1, 5'd2);
      rd++;
    end
    run_r(3'd0, 1'b1, rd, 5'd1, 5'd2);
    run_r(3'd5, 1'b1, rd + 5'd1, 5'd1, 5'd2);
    rd = rd + 5'd2;
    for (int f = 0; f < 8; f++) begin
      noise = xorshift32();
      run_i(3'(f), 1'b0, rd, 5'd1, noise[11:0]);
      rd++;
    end
    noise = xorshift32();
    run_i(3'd5, 1'b1, rd, 5'd1, noise[11:0]);
    wait_retired();
    check_regs();
  endtask

  // each instruction reads the result of the one before it.
  task automatic dependent_chain();
    logic [4:0] prev;
    logic [4:0] prev2;
    logic [31:0] noise;
    prev = 5'd1;
    prev2 = 5'd2;
    for (int i = 0; i < 8; i++) begin
      noise = xorshift32();
      if (i % 2 == 0) begin
        run_r(noise[2:0], (noise[2:0] == 3'd0 || noise[2:0] == 3'd5) && noise[3],
              5'd22 + 5'(i), prev, prev2);
      end else begin
        run_i(noise[2:0], (noise[2:0] == 3'd5) && noise[3], 5'd22 + 5'(i), prev, noise[31:20]);
      end
      prev2 = prev;
      prev = 5'd22 + 5'(i);
    end
    wait_retired();
    check_regs();
  endtask

  // x12 and x14 get compressed forms, x13 and x15 their 32-bit twins.
  task automatic compressed_match_full();
    logic [31:0] noise;
    logic [31:0] imm;
    noise = xorshift32();
    noise[11] = 1'b1; // the c.addi immediate is always negative.
    imm = {{26{noise[5]}}, noise[5:0]};
    issue(ci_word(3'b010, 5'd12, noise[5:0]));
    model_regs[12] = imm;
    run_i(3'd0, 1'b0, 5'd13, 5'd0, imm[11:0]);
    imm = {{26{noise[11]}}, noise[11:6]};
    issue(ci_word(3'b000, 5'd12, noise[11:6]));
    model_regs[12] = model_regs[12] + imm;
    run_i(3'd0, 1'b0, 5'd13, 5'd13, imm[11:0]);
    issue(cr_word(4'b1000, 5'd14, 5'd12));
    model_regs[14] = model_regs[12];
    run_r(3'd0, 1'b0, 5'd15, 5'd0, 5'd13);
    issue(cr_word(4'b1001, 5'd14, 5'd1));
    model_regs[14] = model_regs[14] + model_regs[1];
    run_r(3'd0, 1'b0, 5'd15, 5'd15, 5'd1);
    wait_retired();
    check_regs();
  endtask

  task automatic illegal_words_counted();
    logic [31:0] noise;
    noise = xorshift32();
    issue({12'h010, 5'd1, 3'b010, 5'd3, 7'b0000011}); // load word.
    issue(r_type_word(7'b0000001, 5'd2, 5'd1, 3'd0, 5'd4));
    issue(i_type_word({7'b0100000, 5'd3}, 5'd1, 3'd1, 5'd5));
    issue({noise[31:2], 2'b00}); // quadrant 0 has nothing supported.
    illegal_exp = illegal_exp + 4;
    run_i(3'd0, 1'b0, 5'd0, 5'd1, 12'h123);
    run_r(3'd6, 1'b0, 5'd0, 5'd1, 5'd2);
    wait_retired();
    check_regs();
  endtask

  task automatic bus_errors_rejected();
    logic [1:0] resp;
    axil_write(12'h004, i_type_word(12'h001, 5'd0, 3'd0, 5'd7), 4'hf, resp);
    check_value("bresp", {30'd0, resp}, {30'd0, resp_slverr});
    axil_write(addr_instr, i_type_word(12'h002, 5'd0, 3'd0, 5'd7), 4'h3, resp);
    check_value("bresp", {30'd0, resp}, {30'd0, resp_slverr});
    axil_write(addr_retired, i_type_word(12'h003, 5'd0, 3'd0, 5'd7), 4'hf, resp);
    check_value("bresp", {30'd0, resp}, {30'd0, resp_slverr});
    run_i(3'd0, 1'b0, 5'd7, 5'd0, 12'h005);
    wait_retired();
    check_regs();
    read_expect(12'h088, "rdata", 32'd0, resp_slverr);
    read_expect(12'h040, "rdata", 32'd0, resp_slverr);
    read_expect(12'h102, "rdata", 32'd0, resp_slverr);
    read_expect(12'h180, "rdata", 32'd0, resp_slverr);
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b0;
    axil_req = '0;
    rng_state = 32'd16;
    retired_exp = 0;
    illegal_exp = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b1;
    reset_state_reads_zero();
    alu_ops_match_model();
    dependent_chain();
    compressed_match_full();
    illegal_words_counted();
    bus_errors_rejected();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: flist.f
+incdir+sim
design/rv_pkg.sv
design/axil_port.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/rv_issue_top.sv
sim/tb_rv_issue.sv

// File: Bender.yml
package:
  name: rv_issue

sources:
  - files:
      - design/rv_pkg.sv
      - design/axil_port.sv
      - design/decode_stage.sv
      - design/execute_stage.sv
      - design/result_stage.sv
      - design/rv_issue_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_rv_issue.sv
